//--- design/mbox_buffer.sv
/*
 * mailbox message buffer
 * register-file store with write and read pointers, the clamped message
 * length and the preloaded data-out word
 */
`timescale 1ns/1ns

module mbox_buffer
    import mbox_proto_pkg::*;
(
    input  logic        clk,
    input  logic        rst_b,
    input  logic [31:0] pwdata,
    input  logic [31:0] dlen,
    input  logic        wr_inc,
    input  logic        wr_rst,
    input  logic        rd_inc,
    input  logic        rd_rst,
    input  logic        len_latch,
    output logic [31:0] dataout
);

    logic [31:0]           mem [MBOX_DEPTH];
    logic [MBOX_CNT_W-1:0] wr_ptr;
    logic [MBOX_CNT_W-1:0] rd_ptr;
    logic [MBOX_CNT_W-1:0] rd_len;
    logic [MBOX_CNT_W-1:0] dlen_words;
    logic [MBOX_CNT_W-1:0] len_nxt;
    logic                  wr_en;

    // writes stop once the last entry is filled
    assign wr_en = wr_inc && (wr_ptr < MBOX_CNT_W'(MBOX_DEPTH));

    // programmed length in words, rounded up and capped at the depth
    always_comb begin
        if (dlen >= 32'(MBOX_SIZE_BYTES)) begin
            dlen_words = MBOX_CNT_W'(MBOX_DEPTH);
        end else begin
            dlen_words = {1'b0, dlen[MBOX_PTR_W+1:2]} + MBOX_CNT_W'(dlen[1:0] != 2'b00);
        end
        // a short sender must not let the receiver read stale entries
        len_nxt = (wr_ptr < dlen_words) ? wr_ptr : dlen_words;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[MBOX_PTR_W-1:0]] <= pwdata;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rd_len  <= '0;
            dataout <= '0;
        end else begin
            if (wr_rst) begin
                wr_ptr <= '0;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + MBOX_CNT_W'(1);
            end
            if (len_latch) begin
                rd_len <= len_nxt;
            end
            // rd_rst comes with len_latch, so the new length decides word 0
            if (rd_rst) begin
                rd_ptr  <= MBOX_CNT_W'(1);
                dataout <= (len_nxt != '0) ? mem[0] : '0;
            end else if (rd_inc) begin
                if (rd_ptr < rd_len) begin
                    dataout <= mem[rd_ptr[MBOX_PTR_W-1:0]];
                    rd_ptr  <= rd_ptr + MBOX_CNT_W'(1);
                end else begin
                    dataout <= '0;
                end
            end
        end
    end

endmodule

//--- design/mbox_csr.sv
/*
 * mailbox register block
 * APB slave that decodes the register map and completes each transfer in its
 * access cycle, holds the software visible registers and raises one-cycle
 * access strobes for the protocol FSM
 */
`timescale 1ns/1ns

module mbox_csr
    import mbox_reg_pkg::*;
    import mbox_proto_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  logic                  soc_req,
    input  logic                  accept,
    input  logic                  lock_clr,
    input  logic                  execute_clr,
    input  mbox_state_e           state,
    input  logic                  soc_has_lock,
    input  logic [APB_DATA_W-1:0] dataout,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  lock_rd,
    output logic                  cmd_wr,
    output logic                  dlen_wr,
    output logic                  datain_wr,
    output logic                  dataout_rd,
    output logic                  execute_wr,
    output logic                  status_wr,
    output logic                  unlock_wr,
    output logic                  acc_soc,
    output logic                  lock,
    output logic                  execute,
    output cmd_status_e           cmd_status,
    output logic [APB_DATA_W-1:0] dlen
);

    logic                  access;
    logic                  wr_acc;
    logic                  rd_acc;
    logic                  addr_hit;
    logic [APB_DATA_W-1:0] cmd_q;
    logic                  execute_q;

    // no wait states, the access cycle always completes
    assign pready = 1'b1;
    assign access = psel & penable;
    assign wr_acc = access & pwrite;
    assign rd_acc = access & ~pwrite;

    // the map is eight contiguous words starting at offset 0
    assign addr_hit = (paddr[1:0] == 2'b00) && (paddr <= REG_UNLOCK);
    assign pslverr  = access & ~addr_hit;

    // agent that owns the transfer on the bus right now
    assign acc_soc = psel & soc_req;

    assign lock_rd    = rd_acc & (paddr == REG_LOCK);
    assign cmd_wr     = wr_acc & (paddr == REG_CMD);
    assign dlen_wr    = wr_acc & (paddr == REG_DLEN);
    assign datain_wr  = wr_acc & (paddr == REG_DATAIN);
    assign dataout_rd = rd_acc & (paddr == REG_DATAOUT);
    assign execute_wr = wr_acc & (paddr == REG_EXECUTE);
    assign status_wr  = wr_acc & (paddr == REG_STATUS);
    // only a write of 1 requests the forced unlock
    assign unlock_wr  = wr_acc & (paddr == REG_UNLOCK) & pwdata[0];

    // the FSM sees the value being written to execute, so that its arcs and
    // the data-out preload land on the same completing edge as the write
    assign execute = execute_wr ? pwdata[0] : execute_q;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock       <= 1'b0;
            cmd_q      <= '0;
            dlen       <= '0;
            execute_q  <= 1'b0;
            cmd_status <= CMD_BUSY;
        end else begin
            // reading a free lock takes it, whoever the reader is
            if (lock_clr) begin
                lock <= 1'b0;
            end else if (lock_rd && !lock) begin
                lock <= 1'b1;
            end
            if (cmd_wr && accept) begin
                cmd_q <= pwdata;
            end
            if (dlen_wr && accept) begin
                dlen <= pwdata;
            end
            if (execute_clr) begin
                execute_q <= 1'b0;
            end else if (execute_wr && accept) begin
                execute_q <= pwdata[0];
            end
            // status goes back to busy whenever the mailbox is released
            if (lock_clr) begin
                cmd_status <= CMD_BUSY;
            end else if (status_wr && accept) begin
                cmd_status <= cmd_status_e'(pwdata[STATUS_CMD_LSB +: $bits(cmd_status_e)]);
            end
        end
    end

    // read data reflects register values ahead of the completing edge
    always_comb begin
        prdata = '0;
        if (rd_acc) begin
            case (paddr)
                REG_LOCK:    prdata[0] = lock;
                REG_CMD:     prdata = cmd_q;
                REG_DLEN:    prdata = dlen;
                // data is masked for anyone but the receiver
                REG_DATAOUT: prdata = accept ? dataout : '0;
                REG_EXECUTE: prdata[0] = execute_q;
                REG_STATUS: begin
                    prdata[STATUS_CMD_LSB +: $bits(cmd_status_e)] = cmd_status;
                    prdata[STATUS_FSM_LSB +: $bits(mbox_state_e)] = state;
                    prdata[STATUS_SOC_LOCK_BIT] = soc_has_lock;
                end
                default:     prdata = '0;
            endcase
        end
    end

endmodule

//--- design/mbox_fsm.sv
/*
 * mailbox protocol FSM
 * tracks the lock owner, walks the command/length/data/execute order,
 * checks requester and receiver rights and raises the error pulses
 */
`timescale 1ns/1ns

module mbox_fsm
    import mbox_proto_pkg::*;
(
    input  logic        clk,
    input  logic        rst_b,
    input  logic        lock_rd,
    input  logic        cmd_wr,
    input  logic        dlen_wr,
    input  logic        datain_wr,
    input  logic        dataout_rd,
    input  logic        execute_wr,
    input  logic        status_wr,
    input  logic        unlock_wr,
    input  logic        acc_soc,
    input  logic        lock,
    input  logic        execute,
    input  cmd_status_e cmd_status,
    output mbox_state_e state,
    output logic        soc_has_lock,
    output logic        accept,
    output logic        lock_clr,
    output logic        execute_clr,
    output logic        wr_inc,
    output logic        wr_rst,
    output logic        rd_inc,
    output logic        rd_rst,
    output logic        len_latch,
    output logic        protocol_error_order,
    output logic        protocol_error_nolock,
    output logic        inv_axs,
    output logic        uc_data_avail,
    output logic        soc_data_avail,
    output logic        uc_mbox_lock
);

    mbox_state_e state_nxt;
    logic exec_st;
    logic ordered_st;
    logic requester;
    logic receiver;
    logic status_open;
    logic any_acc;
    logic req_ok;
    logic rcv_ok;
    logic lock_take;
    logic release_lock;
    logic force_unlock;
    logic order_err;
    logic nolock_err;
    logic drop_err;

    assign exec_st    = (state == EXECUTE_UC) || (state == EXECUTE_SOC);
    assign ordered_st = (state == RDY_FOR_CMD) || (state == RDY_FOR_DLEN) ||
                        (state == RDY_FOR_DATA);

    // the requester is the lock owner, the receiver is the other agent and
    // only counts while the message is handed over
    assign requester = lock && (acc_soc == soc_has_lock);
    assign receiver  = lock && (acc_soc != soc_has_lock) && exec_st;

    // a final status (complete or failure) cannot be overwritten before release
    assign status_open = (cmd_status == CMD_BUSY) || (cmd_status == DATA_READY);

    // every access the protocol cares about, reads of other registers are free
    assign any_acc = cmd_wr | dlen_wr | datain_wr | execute_wr | status_wr |
                     unlock_wr | dataout_rd;

    // which requester write each state expects
    always_comb begin
        case (state)
            RDY_FOR_CMD:             req_ok = cmd_wr;
            RDY_FOR_DLEN:            req_ok = dlen_wr;
            RDY_FOR_DATA:            req_ok = datain_wr | execute_wr;
            EXECUTE_UC, EXECUTE_SOC: req_ok = execute_wr;
            default:                 req_ok = 1'b0;
        endcase
        req_ok = req_ok & requester;
    end

    assign rcv_ok = receiver && (dataout_rd || (status_wr && status_open));
    assign accept = req_ok | rcv_ok;

    assign lock_take    = lock_rd && !lock && (state == IDLE);
    assign release_lock = exec_st && req_ok && !execute;
    // the uC may force the mailbox free from any state
    assign force_unlock = unlock_wr && !acc_soc;

    assign nolock_err = (state == IDLE) && acc_soc && any_acc;
    assign order_err  = ordered_st && requester && any_acc && !req_ok && !force_unlock;
    // anything else that is not accepted is dropped silently apart from the pulse
    assign drop_err   = any_acc && !accept && !order_err && !nolock_err && !force_unlock;

    assign lock_clr    = release_lock | force_unlock;
    assign execute_clr = force_unlock;

    always_comb begin
        state_nxt = state;
        wr_inc    = 1'b0;
        wr_rst    = 1'b0;
        rd_inc    = 1'b0;
        rd_rst    = 1'b0;
        len_latch = 1'b0;
        case (state)
            IDLE: begin
                if (lock_take) begin
                    state_nxt = RDY_FOR_CMD;
                end
            end
            RDY_FOR_CMD: begin
                if (req_ok) begin
                    state_nxt = RDY_FOR_DLEN;
                end
            end
            RDY_FOR_DLEN: begin
                // a new message starts filling from word 0
                if (req_ok) begin
                    state_nxt = RDY_FOR_DATA;
                    wr_rst    = 1'b1;
                end
            end
            RDY_FOR_DATA: begin
                wr_inc = req_ok && datain_wr;
                // the SoC's message goes to the uC and the other way round
                if (req_ok && execute_wr && execute) begin
                    state_nxt = soc_has_lock ? EXECUTE_UC : EXECUTE_SOC;
                    len_latch = 1'b1;
                    rd_rst    = 1'b1;
                end
            end
            EXECUTE_UC, EXECUTE_SOC: begin
                rd_inc = rcv_ok && dataout_rd;
                if (release_lock) begin
                    state_nxt = IDLE;
                end
            end
            // ERROR holds until the forced unlock
            default: state_nxt = state;
        endcase
        if (order_err) begin
            state_nxt = ERROR;
        end
        if (force_unlock) begin
            state_nxt = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state                 <= IDLE;
            soc_has_lock          <= 1'b0;
            protocol_error_order  <= 1'b0;
            protocol_error_nolock <= 1'b0;
            inv_axs               <= 1'b0;
        end else begin
            state <= state_nxt;
            // owner is recorded when the lock is taken and forgotten on release
            if (lock_clr) begin
                soc_has_lock <= 1'b0;
            end else if (lock_take) begin
                soc_has_lock <= acc_soc;
            end
            protocol_error_order  <= order_err;
            protocol_error_nolock <= nolock_err;
            inv_axs               <= drop_err;
        end
    end

    assign uc_data_avail  = (state == EXECUTE_UC);
    assign soc_data_avail = (state == EXECUTE_SOC);
    assign uc_mbox_lock   = lock && !soc_has_lock;

endmodule

//--- design/mbox_proto_pkg.sv
/*
 * mailbox protocol definitions
 * FSM states, command status codes and message buffer sizing
 */
package mbox_proto_pkg;

    // protocol FSM states, the encoding shows up in STATUS
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        RDY_FOR_CMD  = 3'd1,
        RDY_FOR_DLEN = 3'd2,
        RDY_FOR_DATA = 3'd3,
        EXECUTE_UC   = 3'd4,
        EXECUTE_SOC  = 3'd5,
        ERROR        = 3'd6
    } mbox_state_e;

    // command status written by the receiver
    typedef enum logic [3:0] {
        CMD_BUSY     = 4'd0,
        DATA_READY   = 4'd1,
        CMD_COMPLETE = 4'd2,
        CMD_FAILURE  = 4'd3
    } cmd_status_e;

    // message store of 64 words of 32 bits
    localparam int MBOX_DEPTH = 64;
    localparam int MBOX_PTR_W = 6;
    // one bit wider than the pointer so a count can reach the full depth
    localparam int MBOX_CNT_W = 7;
    localparam int MBOX_SIZE_BYTES = 256;

endpackage

//--- design/mbox_reg_pkg.sv
/*
 * mailbox register map
 * APB widths, register offsets and the field layout of the STATUS register
 */
package mbox_reg_pkg;

    // APB port widths
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // word aligned register offsets, contiguous from LOCK to UNLOCK
    localparam logic [APB_ADDR_W-1:0] REG_LOCK    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_CMD     = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_DLEN    = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_DATAIN  = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_DATAOUT = 8'h10;
    localparam logic [APB_ADDR_W-1:0] REG_EXECUTE = 8'h14;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS  = 8'h18;
    localparam logic [APB_ADDR_W-1:0] REG_UNLOCK  = 8'h1C;

    // STATUS fields
    // the command status sits in bits 3..0
    localparam int STATUS_CMD_LSB = 0;
    // the FSM state sits in bits 6..4
    localparam int STATUS_FSM_LSB = 4;
    // set when the SoC side owns the lock
    localparam int STATUS_SOC_LOCK_BIT = 7;

endpackage

//--- design/mbox_top.sv
/*
 * mailbox top level
 * connects the APB register block, the protocol FSM and the message buffer
 */
`timescale 1ns/1ns

module mbox_top
    import mbox_reg_pkg::*;
    import mbox_proto_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    input  logic                  soc_req,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  protocol_error_order,
    output logic                  protocol_error_nolock,
    output logic                  inv_axs,
    output logic                  uc_data_avail,
    output logic                  soc_data_avail,
    output logic                  uc_mbox_lock
);

    // strobes and register fields from the register block
    logic lock_rd, cmd_wr, dlen_wr, datain_wr, dataout_rd;
    logic execute_wr, status_wr, unlock_wr;
    logic acc_soc, lock, execute;
    cmd_status_e cmd_status;
    logic [APB_DATA_W-1:0] dlen;
    // FSM controls
    mbox_state_e state;
    logic soc_has_lock, accept, lock_clr, execute_clr;
    logic wr_inc, wr_rst, rd_inc, rd_rst, len_latch;
    // preloaded read word from the buffer
    logic [APB_DATA_W-1:0] dataout;

    mbox_csr u_csr (
        .clk(clk), .rst_b(rst_b), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .soc_req(soc_req), .accept(accept),
        .lock_clr(lock_clr), .execute_clr(execute_clr), .state(state),
        .soc_has_lock(soc_has_lock), .dataout(dataout), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .lock_rd(lock_rd), .cmd_wr(cmd_wr),
        .dlen_wr(dlen_wr), .datain_wr(datain_wr), .dataout_rd(dataout_rd),
        .execute_wr(execute_wr), .status_wr(status_wr), .unlock_wr(unlock_wr),
        .acc_soc(acc_soc), .lock(lock), .execute(execute), .cmd_status(cmd_status),
        .dlen(dlen)
    );

    mbox_fsm u_fsm (
        .clk(clk), .rst_b(rst_b), .lock_rd(lock_rd), .cmd_wr(cmd_wr), .dlen_wr(dlen_wr),
        .datain_wr(datain_wr), .dataout_rd(dataout_rd), .execute_wr(execute_wr),
        .status_wr(status_wr), .unlock_wr(unlock_wr), .acc_soc(acc_soc), .lock(lock),
        .execute(execute), .cmd_status(cmd_status), .state(state),
        .soc_has_lock(soc_has_lock), .accept(accept), .lock_clr(lock_clr),
        .execute_clr(execute_clr), .wr_inc(wr_inc), .wr_rst(wr_rst), .rd_inc(rd_inc),
        .rd_rst(rd_rst), .len_latch(len_latch),
        .protocol_error_order(protocol_error_order),
        .protocol_error_nolock(protocol_error_nolock), .inv_axs(inv_axs),
        .uc_data_avail(uc_data_avail), .soc_data_avail(soc_data_avail),
        .uc_mbox_lock(uc_mbox_lock)
    );

    mbox_buffer u_buffer (
        .clk(clk), .rst_b(rst_b), .pwdata(pwdata), .dlen(dlen), .wr_inc(wr_inc),
        .wr_rst(wr_rst), .rd_inc(rd_inc), .rd_rst(rd_rst), .len_latch(len_latch),
        .dataout(dataout)
    );

endmodule

//--- run.sh
#!/bin/sh
# compile the mailbox testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
        --top-module mbox_tb -o mbox_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mbox_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- include/mbox_tb_tasks.svh
/*
 * mailbox testbench tasks
 * APB transfer driver, compare and level checks and the result counters,
 * meant to be included inside the testbench module
 */
`ifndef MBOX_TB_TASKS_SVH
`define MBOX_TB_TASKS_SVH

// result counters
int unsigned n_checks;
int unsigned n_errors;

// prints a FAILED line when the two values differ
task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
        n_errors++;
        $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

// one APB transfer, called 5 ns after a rising edge and returning 5 ns after
// the completing edge, so the pulses of this transfer are visible on return
task automatic apb_xfer(input logic soc, input logic wr, input logic [APB_ADDR_W-1:0] addr,
                        input logic [APB_DATA_W-1:0] wdata,
                        output logic [APB_DATA_W-1:0] rdata, output logic err);
    // setup cycle
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    soc_req = soc;
    @(posedge clk);
    #5;
    // the access cycle is sampled well before the completing edge
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    // the slave never inserts wait states
    compare("pready", 32'(pready), 32'd1);
    @(posedge clk);
    #5;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

// mask bits from the top are order, nolock, inv_axs, uc avail, soc avail and uc lock
task automatic check_levels(input logic [5:0] exp_mask);
    compare("protocol_error_order", 32'(protocol_error_order), 32'(exp_mask[5]));
    compare("protocol_error_nolock", 32'(protocol_error_nolock), 32'(exp_mask[4]));
    compare("inv_axs", 32'(inv_axs), 32'(exp_mask[3]));
    compare("uc_data_avail", 32'(uc_data_avail), 32'(exp_mask[2]));
    compare("soc_data_avail", 32'(soc_data_avail), 32'(exp_mask[1]));
    compare("uc_mbox_lock", 32'(uc_mbox_lock), 32'(exp_mask[0]));
endtask

`endif

//--- sim/mbox_tb.sv
/*
 * mailbox testbench
 * applies a table of APB transfers from the SoC and the uC to the mailbox and
 * checks read data, slave errors, error pulses and status levels after each one
 */
`timescale 1ns/1ns

module mbox_tb
    import mbox_reg_pkg::*;
    import mbox_proto_pkg::*;
();

    // agent select values for soc_req
    localparam logic SOC = 1'b1;
    localparam logic UC  = 1'b0;

    // expected level bits, same order as the check task in the include file
    localparam logic [5:0] M_NONE   = 6'b000000;
    localparam logic [5:0] M_ORDER  = 6'b100000;
    localparam logic [5:0] M_NOLOCK = 6'b010000;
    localparam logic [5:0] M_INV    = 6'b001000;
    localparam logic [5:0] M_UCAV   = 6'b000100;
    localparam logic [5:0] M_SOCAV  = 6'b000010;
    localparam logic [5:0] M_UCLK   = 6'b000001;

    // one APB transfer with what should come back from it
    typedef struct {
        logic                  soc;
        logic                  wr;
        logic [APB_ADDR_W-1:0] addr;
        logic [APB_DATA_W-1:0] wdata;
        logic [APB_DATA_W-1:0] exp_rdata;
        logic                  exp_err;
        logic [5:0]            exp_mask;
        int                    test;
    } row_t;

    logic                  clk;
    logic                  rst_b;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic                  soc_req;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  protocol_error_order;
    logic                  protocol_error_nolock;
    logic                  inv_axs;
    logic                  uc_data_avail;
    logic                  soc_data_avail;
    logic                  uc_mbox_lock;

    row_t        rows[$];
    int          cur_test;
    bit          table_ready = 1'b0;
    logic [31:0] payload [7];
    string       test_name [1:6];
    int          cycle_cnt;
    int          cycle_limit;

    `include "mbox_tb_tasks.svh"

    mbox_top dut (
        .clk(clk), .rst_b(rst_b), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .soc_req(soc_req), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .protocol_error_order(protocol_error_order),
        .protocol_error_nolock(protocol_error_nolock), .inv_axs(inv_axs),
        .uc_data_avail(uc_data_avail), .soc_data_avail(soc_data_avail),
        .uc_mbox_lock(uc_mbox_lock)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // STATUS as the register map lays it out
    function automatic logic [31:0] status_word(input logic [3:0] cmd,
                                                input logic [2:0] st,
                                                input logic soc_lk);
        return {24'b0, soc_lk, st, cmd};
    endfunction

    function automatic void add_write(input logic soc, input logic [APB_ADDR_W-1:0] addr,
                                      input logic [31:0] data, input logic [5:0] mask);
        row_t r;
        r = '{soc, 1'b1, addr, data, 32'd0, 1'b0, mask, cur_test};
        rows.push_back(r);
    endfunction

    function automatic void add_read(input logic soc, input logic [APB_ADDR_W-1:0] addr,
                                     input logic [31:0] exp, input logic err,
                                     input logic [5:0] mask);
        row_t r;
        r = '{soc, 1'b0, addr, 32'd0, exp, err, mask, cur_test};
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        // the first reader of a free lock owns it, a second read sees it taken
        cur_test = 1;
        add_read(SOC, REG_LOCK, 32'd0, 1'b0, M_NONE);
        add_read(UC, REG_LOCK, 32'd1, 1'b0, M_NONE);
        add_read(SOC, REG_STATUS, status_word(CMD_BUSY, RDY_FOR_CMD, 1'b1), 1'b0, M_NONE);

        // 10 bytes round up to 3 words, the 4th read runs past the message
        cur_test = 2;
        add_write(SOC, REG_CMD, 32'h0000_00A5, M_NONE);
        add_write(SOC, REG_DLEN, 32'd10, M_NONE);
        for (int i = 0; i < 3; i++) begin
            add_write(SOC, REG_DATAIN, payload[i], M_NONE);
        end
        add_write(SOC, REG_EXECUTE, 32'd1, M_UCAV);
        add_read(SOC, REG_STATUS, status_word(CMD_BUSY, EXECUTE_UC, 1'b1), 1'b0, M_UCAV);
        for (int i = 0; i < 3; i++) begin
            add_read(UC, REG_DATAOUT, payload[i], 1'b0, M_UCAV);
        end
        add_read(UC, REG_DATAOUT, 32'd0, 1'b0, M_UCAV);

        // release by the SoC, then the uC sends 8 bytes the other way
        cur_test = 3;
        add_write(UC, REG_STATUS, 32'(CMD_COMPLETE), M_UCAV);
        add_read(SOC, REG_STATUS, status_word(CMD_COMPLETE, EXECUTE_UC, 1'b1), 1'b0, M_UCAV);
        add_write(SOC, REG_EXECUTE, 32'd0, M_NONE);
        add_read(SOC, REG_STATUS, status_word(CMD_BUSY, IDLE, 1'b0), 1'b0, M_NONE);
        add_read(UC, REG_LOCK, 32'd0, 1'b0, M_UCLK);
        add_write(UC, REG_CMD, 32'h0000_005A, M_UCLK);
        add_write(UC, REG_DLEN, 32'd8, M_UCLK);
        add_write(UC, REG_DATAIN, payload[3], M_UCLK);
        add_write(UC, REG_DATAIN, payload[4], M_UCLK);
        add_write(UC, REG_EXECUTE, 32'd1, M_SOCAV | M_UCLK);
        add_read(SOC, REG_DATAOUT, payload[3], 1'b0, M_SOCAV | M_UCLK);
        add_read(SOC, REG_DATAOUT, payload[4], 1'b0, M_SOCAV | M_UCLK);
        add_read(SOC, REG_DATAOUT, 32'd0, 1'b0, M_SOCAV | M_UCLK);
        add_write(SOC, REG_STATUS, 32'(CMD_COMPLETE), M_SOCAV | M_UCLK);
        add_write(UC, REG_EXECUTE, 32'd0, M_NONE);

        // 16 bytes announced but only 2 words written, so reads stop after 2
        cur_test = 4;
        add_read(SOC, REG_LOCK, 32'd0, 1'b0, M_NONE);
        add_write(SOC, REG_CMD, 32'h0000_003C, M_NONE);
        add_write(SOC, REG_DLEN, 32'd16, M_NONE);
        add_write(SOC, REG_DATAIN, payload[5], M_NONE);
        add_write(SOC, REG_DATAIN, payload[6], M_NONE);
        add_write(SOC, REG_EXECUTE, 32'd1, M_UCAV);
        add_read(UC, REG_DATAOUT, payload[5], 1'b0, M_UCAV);
        add_read(UC, REG_DATAOUT, payload[6], 1'b0, M_UCAV);
        add_read(UC, REG_DATAOUT, 32'd0, 1'b0, M_UCAV);
        add_write(UC, REG_STATUS, 32'(CMD_COMPLETE), M_UCAV);
        add_write(SOC, REG_EXECUTE, 32'd0, M_NONE);

        // data before the command sends the FSM to ERROR until the uC unlocks
        cur_test = 5;
        add_read(SOC, REG_LOCK, 32'd0, 1'b0, M_NONE);
        add_write(SOC, REG_DATAIN, 32'h0000_1234, M_ORDER);
        add_read(SOC, REG_STATUS, status_word(CMD_BUSY, ERROR, 1'b1), 1'b0, M_NONE);
        add_write(UC, REG_UNLOCK, 32'd1, M_NONE);
        add_read(SOC, REG_STATUS, status_word(CMD_BUSY, IDLE, 1'b0), 1'b0, M_NONE);
        add_write(SOC, REG_CMD, 32'h0000_0077, M_NOLOCK);

        // the uC is not the requester here, so its CMD write is dropped
        cur_test = 6;
        add_read(SOC, REG_LOCK, 32'd0, 1'b0, M_NONE);
        add_write(UC, REG_CMD, 32'h0000_DEAD, M_INV);
        add_read(SOC, REG_CMD, 32'h0000_003C, 1'b0, M_NONE);
        add_read(SOC, REG_STATUS, status_word(CMD_BUSY, RDY_FOR_CMD, 1'b1), 1'b0, M_NONE);
        add_read(SOC, 8'h20, 32'd0, 1'b1, M_NONE);
        add_write(UC, REG_UNLOCK, 32'd1, M_NONE);
    endfunction

    initial begin
        row_t        r;
        logic [31:0] rdata;
        logic        err;
        int unsigned err_base;
        int unsigned n_tests;

        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        soc_req  = 1'b0;
        rst_b    = 1'b0;
        err_base = 0;
        n_tests  = 0;
        test_name[1] = "lock";
        test_name[2] = "soc to uc message";
        test_name[3] = "release and reverse";
        test_name[4] = "short write clamp";
        test_name[5] = "protocol errors";
        test_name[6] = "dropped access";

        void'($urandom(32'he4f3d913));
        for (int i = 0; i < 7; i++) begin
            payload[i] = $urandom();
        end
        build_table();
        table_ready = 1'b1;

        repeat (4) @(posedge clk);
        #5;
        rst_b = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            apb_xfer(r.soc, r.wr, r.addr, r.wdata, rdata, err);
            if (!r.wr) begin
                compare("prdata", rdata, r.exp_rdata);
            end
            compare("pslverr", 32'(err), 32'(r.exp_err));
            check_levels(r.exp_mask);
            // a test ends where the next row belongs to another one
            if ((i == rows.size() - 1) || (rows[i + 1].test != r.test)) begin
                $display("test %0d %s: %s", r.test, test_name[r.test],
                         (n_errors == err_base) ? "ok" : "failed");
                err_base = n_errors;
                n_tests++;
            end
        end

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // every transfer takes two cycles, the rest is margin for reset
    initial begin
        wait (table_ready);
        cycle_limit = rows.size() * 2 + 50;
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the table did not finish within %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
design/mbox_reg_pkg.sv
design/mbox_proto_pkg.sv
design/mbox_csr.sv
design/mbox_fsm.sv
design/mbox_buffer.sv
design/mbox_top.sv
sim/mbox_tb.sv
